/* build.f */
+incdir+test
design/rename_pkg.sv
design/rat.sv
design/rob_alloc.sv
design/rename_stage.sv
design/rename_top.sv
test/rename_tb.sv

/* Makefile */
TOP := rename_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* test/rename_tb_table.svh */
// rename columns: valid, slot0 src1 src2 dst, slot1 src1 src2 dst,
// src1 busy {s1,s0}, tags s0 s1, src2 busy {s1,s0}, tags s0 s1, dst tags s0 s1, stall, free_n

// fresh table, everything architectural, tags 0 and 1
add_rename(2'b11,  1,  2,  3,   4,  5,  6,
           2'b00,  0,  0,  2'b00,  0,  0,   0,  1,  1'b0, 0);
// reads of r3 and r6, dst 0 takes no tag
add_rename(2'b11,  3,  6,  0,   6,  7,  8,
           2'b11,  0,  1,  2'b01,  1,  0,   0,  2,  1'b0, 0);
// slot1 sees slot0's new r3 tag, not the old one
add_rename(2'b11,  8,  1,  3,   3,  8,  9,
           2'b11,  2,  3,  2'b10,  0,  2,   3,  4,  1'b0, 0);
// both slots write r11, slot1 should own it
add_rename(2'b11,  1,  2, 11,   5, 11, 11,
           2'b00,  0,  0,  2'b10,  0,  5,   5,  6,  1'b0, 0);
// r11 from slot1 of the last group
add_rename(2'b11, 11,  9, 12,   3, 12,  0,
           2'b11,  6,  3,  2'b11,  4,  7,   7,  0,  1'b0, 0);
// fill up to tag 15
add_rename(2'b11, 12, 16, 16,  16,  6, 17,
           2'b11,  7,  8,  2'b10,  0,  1,   8,  9,  1'b0, 0);
add_rename(2'b11, 17,  1, 18,   2, 18, 19,
           2'b01,  9,  0,  2'b10,  0, 10,  10, 11,  1'b0, 0);
add_rename(2'b11, 19, 18, 20,  20, 20, 21,
           2'b11, 11, 12,  2'b11, 10, 12,  12, 13,  1'b0, 0);
add_rename(2'b11, 21,  5, 22,   0, 22, 23,
           2'b01, 13,  0,  2'b10,  0, 14,  14, 15,  1'b0, 0);
// rob full, retire of tags 0 and 1 frees it
// r6 cleared, r3 kept its newer tag 3, new tags wrap to 0 and 1
add_rename(2'b11,  6,  3, 24,  24, 23,  6,
           2'b10,  0,  0,  2'b11,  3, 15,   0,  1,  1'b1, 2);
// tag 2 clears r8, then tags 3 and 4 clear r3 and r9
add_retire(1);
add_retire(2);
add_rename(2'b11,  3,  8,  3,   9,  6,  0,
           2'b00,  0,  0,  2'b10,  0,  1,   2,  0,  1'b0, 0);
// tags 5 and 6 clear r11
add_retire(2);
add_rename(2'b11, 11, 12, 25,   3, 24, 26,
           2'b10,  0,  2,  2'b11,  7,  0,   3,  4,  1'b0, 0);

/* test/rename_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_tb
    import rename_pkg::*;
();

    localparam int W     = MACHINE_WIDTH;
    localparam int CNT_W = $clog2(W + 1);
    // ack wait bound and the window in which a stalled rename must stay quiet
    localparam int ACK_LIMIT    = 50;
    localparam int STALL_WINDOW = 20;

    // one operation with the results it should produce
    typedef struct packed {
        logic              is_retire;
        logic              stall;
        logic [CNT_W-1:0]  rt_count;
        logic [W-1:0]      valid;
        arch_reg_t [W-1:0] src1;
        arch_reg_t [W-1:0] src2;
        arch_reg_t [W-1:0] dst;
        logic [W-1:0]      exp_src1_busy;
        rob_tag_t [W-1:0]  exp_src1_tag;
        logic [W-1:0]      exp_src2_busy;
        rob_tag_t [W-1:0]  exp_src2_tag;
        rob_tag_t [W-1:0]  exp_dst_tag;
    } row_t;

    logic             clk = 1'b0;
    logic             reset;
    logic             rn_req;
    logic [W-1:0]     rn_valid;
    arch_reg_t        rn_src1 [W];
    arch_reg_t        rn_src2 [W];
    arch_reg_t        rn_dst  [W];
    logic             rn_ack;
    logic [W-1:0]     rn_src1_busy;
    rob_tag_t         rn_src1_tag [W];
    logic [W-1:0]     rn_src2_busy;
    rob_tag_t         rn_src2_tag [W];
    rob_tag_t         rn_dst_tag  [W];
    logic             rt_req;
    logic [CNT_W-1:0] rt_count;
    logic             rt_ack;

    row_t rows [$];
    int   errors;
    int   rows_passed;
    int   rows_failed;
    int   cur_row;
    bit   timed_out;

    always #5 clk = ~clk;

    rename_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .rn_req       (rn_req),
        .rn_valid     (rn_valid),
        .rn_src1      (rn_src1),
        .rn_src2      (rn_src2),
        .rn_dst       (rn_dst),
        .rn_ack       (rn_ack),
        .rn_src1_busy (rn_src1_busy),
        .rn_src1_tag  (rn_src1_tag),
        .rn_src2_busy (rn_src2_busy),
        .rn_src2_tag  (rn_src2_tag),
        .rn_dst_tag   (rn_dst_tag),
        .rt_req       (rt_req),
        .rt_count     (rt_count),
        .rt_ack       (rt_ack)
    );

    // rename row, stall set means a retire of free_n is needed to finish it
    function automatic void add_rename(
        input logic [W-1:0] valid,
        input int s1_0, input int s2_0, input int d_0,
        input int s1_1, input int s2_1, input int d_1,
        input logic [W-1:0] b1, input int t1_0, input int t1_1,
        input logic [W-1:0] b2, input int t2_0, input int t2_1,
        input int dt_0, input int dt_1,
        input logic stall, input int free_n);
        row_t r;
        r                 = '0;
        r.valid           = valid;
        r.src1[0]         = arch_reg_t'(s1_0);
        r.src2[0]         = arch_reg_t'(s2_0);
        r.dst[0]          = arch_reg_t'(d_0);
        r.src1[1]         = arch_reg_t'(s1_1);
        r.src2[1]         = arch_reg_t'(s2_1);
        r.dst[1]          = arch_reg_t'(d_1);
        r.exp_src1_busy   = b1;
        r.exp_src1_tag[0] = rob_tag_t'(t1_0);
        r.exp_src1_tag[1] = rob_tag_t'(t1_1);
        r.exp_src2_busy   = b2;
        r.exp_src2_tag[0] = rob_tag_t'(t2_0);
        r.exp_src2_tag[1] = rob_tag_t'(t2_1);
        r.exp_dst_tag[0]  = rob_tag_t'(dt_0);
        r.exp_dst_tag[1]  = rob_tag_t'(dt_1);
        r.stall           = stall;
        r.rt_count        = CNT_W'(free_n);
        rows.push_back(r);
    endfunction

    function automatic void add_retire(input int count);
        row_t r;
        r           = '0;
        r.is_retire = 1'b1;
        r.rt_count  = CNT_W'(count);
        rows.push_back(r);
    endfunction

    function automatic void load_table();
        `include "rename_tb_table.svh"
    endfunction

    task automatic check_value(input string what, input int got, input int want);
        if (got != want) begin
            errors++;
            $display("mismatch at %0t ns: row %0d %s got %0d expected %0d",
                     $time, cur_row, what, got, want);
        end
    endtask

    task automatic wait_rn_ack(input logic want, output int cycles);
        cycles = 0;
        while (rn_ack !== want && cycles < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (rn_ack !== want) begin
            timed_out = 1'b1;
            $display("timeout in row %0d: rn_ack did not go to %0d within %0d cycles",
                     cur_row, want, ACK_LIMIT);
        end
    endtask

    task automatic wait_rt_ack(input logic want, output int cycles);
        cycles = 0;
        while (rt_ack !== want && cycles < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (rt_ack !== want) begin
            timed_out = 1'b1;
            $display("timeout in row %0d: rt_ack did not go to %0d within %0d cycles",
                     cur_row, want, ACK_LIMIT);
        end
    endtask

    // four-phase retire, ack one cycle after req
    task automatic run_retire(input logic [CNT_W-1:0] count);
        int cycles;
        rt_count = count;
        rt_req   = 1'b1;
        wait_rt_ack(1'b1, cycles);
        if (timed_out) begin
            return;
        end
        check_value("rt_ack latency", cycles, 1);
        rt_req = 1'b0;
        wait_rt_ack(1'b0, cycles);
        if (timed_out) begin
            return;
        end
        check_value("rt_ack release latency", cycles, 1);
    endtask

    // busy flags always, tags only where a producer is expected
    task automatic compare_results(input row_t r);
        for (int i = 0; i < W; i++) begin
            check_value($sformatf("slot %0d src1 busy", i),
                        int'(rn_src1_busy[i]), int'(r.exp_src1_busy[i]));
            if (r.exp_src1_busy[i]) begin
                check_value($sformatf("slot %0d src1 tag", i),
                            int'(rn_src1_tag[i]), int'(r.exp_src1_tag[i]));
            end
            check_value($sformatf("slot %0d src2 busy", i),
                        int'(rn_src2_busy[i]), int'(r.exp_src2_busy[i]));
            if (r.exp_src2_busy[i]) begin
                check_value($sformatf("slot %0d src2 tag", i),
                            int'(rn_src2_tag[i]), int'(r.exp_src2_tag[i]));
            end
            check_value($sformatf("slot %0d dst tag", i),
                        int'(rn_dst_tag[i]), int'(r.exp_dst_tag[i]));
        end
    endtask

    task automatic run_rename(input row_t r);
        int cycles;
        int early_ack;
        rn_valid = r.valid;
        for (int i = 0; i < W; i++) begin
            rn_src1[i] = r.src1[i];
            rn_src2[i] = r.src2[i];
            rn_dst[i]  = r.dst[i];
        end
        rn_req = 1'b1;
        if (r.stall) begin
            // rob full, ack must stay low until space comes back
            early_ack = 0;
            for (int n = 0; n < STALL_WINDOW; n++) begin
                @(posedge clk);
                #1;
                if (rn_ack) begin
                    early_ack = 1;
                end
            end
            check_value("rn_ack while rob full", early_ack, 0);
            // retire with rn_req still held
            run_retire(r.rt_count);
            if (timed_out) begin
                return;
            end
        end
        wait_rn_ack(1'b1, cycles);
        if (timed_out) begin
            return;
        end
        if (!r.stall) begin
            check_value("rn_ack latency", cycles, 1);
        end
        compare_results(r);
        rn_req = 1'b0;
        wait_rn_ack(1'b0, cycles);
        if (timed_out) begin
            return;
        end
        check_value("rn_ack release latency", cycles, 1);
    endtask

    initial begin
        int gap;
        int start_errors;
        errors      = 0;
        rows_passed = 0;
        rows_failed = 0;
        cur_row     = 0;
        timed_out   = 1'b0;
        reset       = 1'b1;
        rn_req      = 1'b0;
        rn_valid    = '0;
        rt_req      = 1'b0;
        rt_count    = '0;
        for (int i = 0; i < W; i++) begin
            rn_src1[i] = '0;
            rn_src2[i] = '0;
            rn_dst[i]  = '0;
        end
        void'($urandom(84137));
        load_table();

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        // both ports idle out of reset
        check_value("rn_ack after reset", int'(rn_ack), 0);
        check_value("rt_ack after reset", int'(rt_ack), 0);
        $display("reset check: %s", (errors == 0) ? "pass" : "FAIL");

        for (int k = 0; k < rows.size(); k++) begin
            cur_row      = k + 1;
            start_errors = errors;
            // idle gap of 0 to 3 cycles
            gap = int'($urandom % 4);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            if (rows[k].is_retire) begin
                run_retire(rows[k].rt_count);
            end else begin
                run_rename(rows[k]);
            end
            if (errors == start_errors && !timed_out) begin
                rows_passed++;
                $display("row %0d %s: pass", cur_row,
                         rows[k].is_retire ? "retire" : "rename");
            end else begin
                rows_failed++;
                $display("row %0d %s: FAIL", cur_row,
                         rows[k].is_retire ? "retire" : "rename");
            end
            if (timed_out) begin
                break;
            end
        end

        $display("summary: %0d rows passed, %0d rows failed, %0d mismatches",
                 rows_passed, rows_failed, errors);
        if (rows_failed == 0 && errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/rename_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_top
    import rename_pkg::*;
#(
    parameter int MACHINE_WIDTH = rename_pkg::MACHINE_WIDTH,
    parameter int ROB_DEPTH     = rename_pkg::ROB_DEPTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rn_req,
    input  logic [MACHINE_WIDTH-1:0]           rn_valid,
    input  arch_reg_t                          rn_src1 [MACHINE_WIDTH],
    input  arch_reg_t                          rn_src2 [MACHINE_WIDTH],
    input  arch_reg_t                          rn_dst  [MACHINE_WIDTH],
    output logic                               rn_ack,
    output logic [MACHINE_WIDTH-1:0]           rn_src1_busy,
    output rob_tag_t                           rn_src1_tag [MACHINE_WIDTH],
    output logic [MACHINE_WIDTH-1:0]           rn_src2_busy,
    output rob_tag_t                           rn_src2_tag [MACHINE_WIDTH],
    output rob_tag_t                           rn_dst_tag  [MACHINE_WIDTH],
    input  logic                               rt_req,
    input  logic [$clog2(MACHINE_WIDTH+1)-1:0] rt_count,
    output logic                               rt_ack
);

    // strobes from the port controllers
    logic rename_fire;
    logic retire_fire;

    // allocator state
    rob_tag_t                           head;
    rob_tag_t                           tail;
    logic [$clog2(ROB_DEPTH+1)-1:0]     free_count;
    logic [$clog2(MACHINE_WIDTH+1)-1:0] alloc_count;

    // combinational lookup results ahead of the output registers
    logic [MACHINE_WIDTH-1:0] lookup_src1_busy;
    rob_tag_t                 lookup_src1_tag [MACHINE_WIDTH];
    logic [MACHINE_WIDTH-1:0] lookup_src2_busy;
    rob_tag_t                 lookup_src2_tag [MACHINE_WIDTH];
    rob_tag_t                 lookup_dst_tag  [MACHINE_WIDTH];

    rename_stage #(
        .MACHINE_WIDTH (MACHINE_WIDTH),
        .ROB_DEPTH     (ROB_DEPTH)
    ) u_stage (
        .clk              (clk),
        .reset            (reset),
        .rn_req           (rn_req),
        .rt_req           (rt_req),
        .free_count       (free_count),
        .alloc_count      (alloc_count),
        .lookup_src1_busy (lookup_src1_busy),
        .lookup_src1_tag  (lookup_src1_tag),
        .lookup_src2_busy (lookup_src2_busy),
        .lookup_src2_tag  (lookup_src2_tag),
        .lookup_dst_tag   (lookup_dst_tag),
        .rename_fire      (rename_fire),
        .retire_fire      (retire_fire),
        .rn_ack           (rn_ack),
        .rt_ack           (rt_ack),
        .rn_src1_busy     (rn_src1_busy),
        .rn_src1_tag      (rn_src1_tag),
        .rn_src2_busy     (rn_src2_busy),
        .rn_src2_tag      (rn_src2_tag),
        .rn_dst_tag       (rn_dst_tag)
    );

    rat #(
        .MACHINE_WIDTH (MACHINE_WIDTH),
        .ROB_DEPTH     (ROB_DEPTH)
    ) u_rat (
        .clk              (clk),
        .reset            (reset),
        .rn_valid         (rn_valid),
        .rn_src1          (rn_src1),
        .rn_src2          (rn_src2),
        .rn_dst           (rn_dst),
        .tail             (tail),
        .head             (head),
        .rename_fire      (rename_fire),
        .retire_fire      (retire_fire),
        .rt_count         (rt_count),
        .lookup_src1_busy (lookup_src1_busy),
        .lookup_src1_tag  (lookup_src1_tag),
        .lookup_src2_busy (lookup_src2_busy),
        .lookup_src2_tag  (lookup_src2_tag),
        .lookup_dst_tag   (lookup_dst_tag),
        .alloc_count      (alloc_count)
    );

    rob_alloc #(
        .MACHINE_WIDTH (MACHINE_WIDTH),
        .ROB_DEPTH     (ROB_DEPTH)
    ) u_rob_alloc (
        .clk         (clk),
        .reset       (reset),
        .rename_fire (rename_fire),
        .alloc_count (alloc_count),
        .retire_fire (retire_fire),
        .rt_count    (rt_count),
        .head        (head),
        .tail        (tail),
        .free_count  (free_count)
    );

endmodule

`default_nettype wire

/* design/rename_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module rename_stage
    import rename_pkg::*;
#(
    parameter int MACHINE_WIDTH = rename_pkg::MACHINE_WIDTH,
    parameter int ROB_DEPTH     = rename_pkg::ROB_DEPTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rn_req,
    input  logic                               rt_req,
    input  logic [$clog2(ROB_DEPTH+1)-1:0]     free_count,
    input  logic [$clog2(MACHINE_WIDTH+1)-1:0] alloc_count,
    input  logic [MACHINE_WIDTH-1:0]           lookup_src1_busy,
    input  rob_tag_t                           lookup_src1_tag [MACHINE_WIDTH],
    input  logic [MACHINE_WIDTH-1:0]           lookup_src2_busy,
    input  rob_tag_t                           lookup_src2_tag [MACHINE_WIDTH],
    input  rob_tag_t                           lookup_dst_tag  [MACHINE_WIDTH],
    output logic                               rename_fire,
    output logic                               retire_fire,
    output logic                               rn_ack,
    output logic                               rt_ack,
    output logic [MACHINE_WIDTH-1:0]           rn_src1_busy,
    output rob_tag_t                           rn_src1_tag [MACHINE_WIDTH],
    output logic [MACHINE_WIDTH-1:0]           rn_src2_busy,
    output rob_tag_t                           rn_src2_tag [MACHINE_WIDTH],
    output rob_tag_t                           rn_dst_tag  [MACHINE_WIDTH]
);

    localparam int OCC_W = $clog2(ROB_DEPTH + 1);

    port_state_e rn_state;
    port_state_e rn_state_d;
    port_state_e rt_state;
    port_state_e rt_state_d;

    // enough free entries for the whole group
    logic rn_room;

    assign rn_room = (free_count >= OCC_W'(alloc_count));

    // rename port
    // busy holds the group while the rob is short
    always_comb begin
        rn_state_d  = rn_state;
        rename_fire = 1'b0;
        case (rn_state)
            state_idle, state_busy: begin
                if (!rn_req) begin
                    rn_state_d = state_idle;
                end else if (rn_room) begin
                    rename_fire = 1'b1;
                    rn_state_d  = state_done;
                end else begin
                    rn_state_d = state_busy;
                end
            end
            state_done: begin
                // hold ack until req drops
                if (!rn_req) begin
                    rn_state_d = state_idle;
                end
            end
            default: rn_state_d = state_idle;
        endcase
    end

    // retire port, never stalls so busy is not used
    always_comb begin
        rt_state_d  = rt_state;
        retire_fire = 1'b0;
        case (rt_state)
            state_idle: begin
                if (rt_req) begin
                    retire_fire = 1'b1;
                    rt_state_d  = state_done;
                end
            end
            state_done: begin
                if (!rt_req) begin
                    rt_state_d = state_idle;
                end
            end
            default: rt_state_d = state_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rn_state <= state_idle;
            rt_state <= state_idle;
        end else begin
            rn_state <= rn_state_d;
            rt_state <= rt_state_d;
        end
    end

    // acks come straight from the state flops
    assign rn_ack = (rn_state == state_done);
    assign rt_ack = (rt_state == state_done);

    // results captured with the fire, stable until the next group
    always_ff @(posedge clk) begin
        if (rename_fire) begin
            rn_src1_busy <= lookup_src1_busy;
            rn_src1_tag  <= lookup_src1_tag;
            rn_src2_busy <= lookup_src2_busy;
            rn_src2_tag  <= lookup_src2_tag;
            rn_dst_tag   <= lookup_dst_tag;
        end
    end

endmodule

`default_nettype wire

/* design/rob_alloc.sv */
`timescale 1ns/100ps
`default_nettype none

module rob_alloc
    import rename_pkg::*;
#(
    parameter int MACHINE_WIDTH = rename_pkg::MACHINE_WIDTH,
    parameter int ROB_DEPTH     = rename_pkg::ROB_DEPTH
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               rename_fire,
    input  logic [$clog2(MACHINE_WIDTH+1)-1:0] alloc_count,
    input  logic                               retire_fire,
    input  logic [$clog2(MACHINE_WIDTH+1)-1:0] rt_count,
    output rob_tag_t                           head,
    output rob_tag_t                           tail,
    output logic [$clog2(ROB_DEPTH+1)-1:0]     free_count
);

    localparam int CNT_W = $clog2(MACHINE_WIDTH + 1);
    localparam int OCC_W = $clog2(ROB_DEPTH + 1);

    // entries between head and tail
    logic [OCC_W-1:0] occupancy;

    // retire amount after clamping
    logic [CNT_W-1:0] release_n;

    // per-cycle occupancy change
    logic [OCC_W-1:0] occ_inc;
    logic [OCC_W-1:0] occ_dec;

    // never release more than is held
    always_comb begin
        int unsigned rel;
        rel = int'(rt_count);
        if (rel > int'(occupancy)) begin
            rel = int'(occupancy);
        end
        release_n = CNT_W'(rel);
    end

    assign occ_inc = rename_fire ? OCC_W'(alloc_count) : '0;
    assign occ_dec = retire_fire ? OCC_W'(release_n) : '0;

    // space seen by the stall check, before any same-cycle retire
    assign free_count = OCC_W'(ROB_DEPTH) - occupancy;

    always_ff @(posedge clk) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            // tail moves past the tags of the group
            if (rename_fire) begin
                tail <= tag_add(tail, int'(alloc_count), ROB_DEPTH);
            end
            // oldest entries leave in order
            if (retire_fire) begin
                head <= tag_add(head, int'(release_n), ROB_DEPTH);
            end
            occupancy <= occupancy + occ_inc - occ_dec;
        end
    end

endmodule

`default_nettype wire

/* design/rat.sv */
`timescale 1ns/100ps
`default_nettype none

module rat
    import rename_pkg::*;
#(
    parameter int MACHINE_WIDTH = rename_pkg::MACHINE_WIDTH,
    parameter int ROB_DEPTH     = rename_pkg::ROB_DEPTH
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [MACHINE_WIDTH-1:0]             rn_valid,
    input  arch_reg_t                            rn_src1 [MACHINE_WIDTH],
    input  arch_reg_t                            rn_src2 [MACHINE_WIDTH],
    input  arch_reg_t                            rn_dst  [MACHINE_WIDTH],
    input  rob_tag_t                             tail,
    input  rob_tag_t                             head,
    input  logic                                 rename_fire,
    input  logic                                 retire_fire,
    input  logic [$clog2(MACHINE_WIDTH+1)-1:0]   rt_count,
    output logic [MACHINE_WIDTH-1:0]             lookup_src1_busy,
    output rob_tag_t                             lookup_src1_tag [MACHINE_WIDTH],
    output logic [MACHINE_WIDTH-1:0]             lookup_src2_busy,
    output rob_tag_t                             lookup_src2_tag [MACHINE_WIDTH],
    output rob_tag_t                             lookup_dst_tag  [MACHINE_WIDTH],
    output logic [$clog2(MACHINE_WIDTH+1)-1:0]   alloc_count
);

    localparam int CNT_W = $clog2(MACHINE_WIDTH + 1);

    // current table, after retire clear, and next state
    rat_entry_t map_q   [ARCH_REGS];
    rat_entry_t map_clr [ARCH_REGS];
    rat_entry_t map_d   [ARCH_REGS];

    // slots that allocate a tag and the tag each would get
    logic [MACHINE_WIDTH-1:0] writes;
    rob_tag_t                 slot_tag [MACHINE_WIDTH];

    // tags handed out in slot order starting at tail
    always_comb begin
        int unsigned n;
        n = 0;
        for (int i = 0; i < MACHINE_WIDTH; i++) begin
            // dst 0 takes no tag
            writes[i]   = rn_valid[i] && (rn_dst[i] != '0);
            slot_tag[i] = tag_add(tail, n, ROB_DEPTH);
            if (writes[i]) begin
                n = n + 1;
            end
        end
        alloc_count = CNT_W'(n);
    end

    // retire clear, only where the entry still names the retiring tag
    always_comb begin
        rob_tag_t rel_tag;
        map_clr = map_q;
        rel_tag = head;
        if (retire_fire) begin
            for (int k = 0; k < MACHINE_WIDTH; k++) begin
                rel_tag = tag_add(head, k, ROB_DEPTH);
                if (k < int'(rt_count)) begin
                    for (int r = 1; r < ARCH_REGS; r++) begin
                        if (map_clr[r].valid && map_clr[r].tag == rel_tag) begin
                            map_clr[r] = '0;
                        end
                    end
                end
            end
        end
    end

    // rename writes go on top of the clear
    // later slot wins on a shared dst
    always_comb begin
        map_d = map_clr;
        if (rename_fire) begin
            for (int i = 0; i < MACHINE_WIDTH; i++) begin
                if (writes[i]) begin
                    map_d[rn_dst[i]].valid = 1'b1;
                    map_d[rn_dst[i]].tag   = slot_tag[i];
                end
            end
        end
    end

    // lookups see the table without this group's writes
    always_comb begin
        for (int i = 0; i < MACHINE_WIDTH; i++) begin
            lookup_src1_busy[i] = map_clr[rn_src1[i]].valid;
            lookup_src1_tag[i]  = map_clr[rn_src1[i]].tag;
            lookup_src2_busy[i] = map_clr[rn_src2[i]].valid;
            lookup_src2_tag[i]  = map_clr[rn_src2[i]].tag;
            // bypass from earlier slots, the nearest producer ends up last
            for (int j = 0; j < i; j++) begin
                if (writes[j] && rn_dst[j] == rn_src1[i]) begin
                    lookup_src1_busy[i] = 1'b1;
                    lookup_src1_tag[i]  = slot_tag[j];
                end
                if (writes[j] && rn_dst[j] == rn_src2[i]) begin
                    lookup_src2_busy[i] = 1'b1;
                    lookup_src2_tag[i]  = slot_tag[j];
                end
            end
            lookup_dst_tag[i] = writes[i] ? slot_tag[i] : '0;
        end
    end

    // all entries invalid out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_q[r] <= '0;
            end
        end else begin
            map_q <= map_d;
        end
    end

endmodule

`default_nettype wire

/* design/rename_pkg.sv */
`default_nettype none

package rename_pkg;

    // default group width and machine sizes
    parameter int MACHINE_WIDTH = 2;
    parameter int ARCH_REGS     = 32;
    parameter int ROB_DEPTH     = 16;

    // index widths
    parameter int ARCH_REG_W = $clog2(ARCH_REGS);
    parameter int ROB_TAG_W  = $clog2(ROB_DEPTH);

    // architectural register index, r0 is hardwired and never renamed
    typedef logic [ARCH_REG_W-1:0] arch_reg_t;

    // rob entry index
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // alias table entry
    // valid set means the register waits on the rob entry in tag
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } rat_entry_t;

    // state of a four-phase port controller
    typedef enum logic [1:0] {
        state_idle = 2'd0,
        state_busy = 2'd1,
        state_done = 2'd2
    } port_state_e;

    // circular tag step, offset has to stay below depth
    function automatic rob_tag_t tag_add(rob_tag_t base, int unsigned offset,
                                         int unsigned depth);
        int unsigned sum;
        sum = int'(base) + offset;
        // single wrap is enough for offsets of one group
        if (sum >= depth) begin
            sum = sum - depth;
        end
        return rob_tag_t'(sum);
    endfunction

endpackage

`default_nettype wire
